// File: Bender.yml
package:
  name: frequency_counter

sources:
  - common/freqCntPkg.sv
  - verilog/edgeSync.sv
  - measure/secondGate.sv
  - measure/rateDivider.sv
  - verilog/axiLiteRegs.sv
  - verilog/frequencyCounter.sv
  - target: simulation
    files:
      - verification/tbFrequencyCounter.sv

// File: common/freqCntPkg.sv
/*
  Shared constants and types of the frequency counter: data widths, the AXI4-Lite
  register map with masks and reset values, response codes and the state enums.
  Modules import it inside their body and use scoped names in port lists.
*/
package freqCntPkg;

  // ****************************************
  // Widths
  // ****************************************
  // Seconds field of the local time
  localparam int SecondWidth = 32;
  // Edge counter and dividend
  localparam int CountWidth = 40;
  // Measurement period in seconds, 1 to 255
  localparam int PeriodWidth = 8;
  // Step counter of the serial divider
  localparam int DivStepWidth = $clog2(CountWidth);

  localparam int AxiAddrWidth = 16;
  localparam int AxiDataWidth = 32;
  localparam int RespWidth = 2;

  // ****************************************
  // Register map
  // ****************************************
  localparam logic [AxiAddrWidth-1:0] ControlAddr = 16'h0000;
  localparam logic [AxiAddrWidth-1:0] FrequencyAddr = 16'h0004;
  localparam logic [AxiAddrWidth-1:0] PolarityAddr = 16'h0008;
  localparam logic [AxiAddrWidth-1:0] VersionAddr = 16'h000C;

  // Writable bits
  localparam logic [AxiDataWidth-1:0] ControlMask = 32'h0000_FF01;
  localparam logic [AxiDataWidth-1:0] PolarityMask = 32'h0000_0001;

  // Enable off, period of one second
  localparam logic [AxiDataWidth-1:0] ControlReset = 32'h0000_0100;
  // Rising edges are counted out of reset
  localparam logic PolarityReset = 1'b1;
  // Major 0, minor 1, build 0
  localparam logic [AxiDataWidth-1:0] FreqCntVersion = 32'h0001_0000;

  // Field positions
  localparam int EnableBit = 0;
  localparam int PeriodLsb = 8;
  localparam int ValidBit = 31;
  localparam int ErrorBit = 30;
  localparam int OverflowBit = 29;
  localparam int FreqValueWidth = 24;

  // Default range limit in Hz
  localparam int MaxFrequency = 10_000_000;

  // AXI response codes
  localparam logic [RespWidth-1:0] RespOkay = 2'b00;
  localparam logic [RespWidth-1:0] RespSlvErr = 2'b10;

  // ****************************************
  // State types
  // ****************************************
  typedef enum logic [1:0] {
    AxiIdle,
    AxiRead,
    AxiWrite,
    AxiResp
  } axiStateT;

  typedef enum logic {
    DivIdle,
    DivRun
  } divStateT;

endpackage

// File: measure/rateDivider.sv
/*
  Serial restoring divider: edge count over period in seconds, one quotient bit
  per cycle. The quotient is checked against FreqLimit and published with a pulse.
*/
module rateDivider #(
  parameter int FreqLimit = freqCntPkg::MaxFrequency
) (
  input  logic                                 SysClk_ClkIn,
  input  logic                                 SysRstN_RstIn,
  input  logic [freqCntPkg::CountWidth-1:0]     measCount,
  input  logic [freqCntPkg::PeriodWidth-1:0]    measPeriod,
  input  logic                                 measValid,
  output logic [freqCntPkg::FreqValueWidth-1:0] freqValue,
  output logic                                 freqOverflow,
  output logic                                 freqDone
);

  import freqCntPkg::*;

  divStateT state;
  logic [DivStepWidth-1:0] stepCnt;

  // Dividend shifts out at the top while quotient bits enter at the bottom
  logic [CountWidth-1:0] quotReg;
  logic [PeriodWidth-1:0] remReg;
  logic [PeriodWidth-1:0] divisorReg;

  logic [PeriodWidth:0] remShift;
  // One extra bit holds the sign of the trial subtraction
  logic [PeriodWidth+1:0] trialDiff;
  // Quotient after the current step
  logic [CountWidth-1:0] quotNext;
  logic overLimit;

  always_comb begin
    remShift = {remReg, quotReg[CountWidth-1]};
    trialDiff = {1'b0, remShift} - {2'b00, divisorReg};
    quotNext = {quotReg[CountWidth-2:0], ~trialDiff[PeriodWidth+1]};
    overLimit = (quotNext > CountWidth'(FreqLimit));
  end

  // ****************************************
  // Control
  // ****************************************
  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      state <= DivIdle;
      stepCnt <= '0;
      freqDone <= 1'b0;
    end else begin
      freqDone <= 1'b0;
      if (measValid) begin
        // A new measurement always restarts the divider
        state <= DivRun;
        stepCnt <= DivStepWidth'(CountWidth - 1);
      end else if (state == DivRun) begin
        if (stepCnt == '0) begin
          // Result is classified together with the last step
          state <= DivIdle;
          freqDone <= 1'b1;
        end else begin
          stepCnt <= stepCnt - DivStepWidth'(1);
        end
      end
    end
  end

  // ****************************************
  // Datapath
  // ****************************************
  always_ff @(posedge SysClk_ClkIn) begin
    if (measValid) begin
      quotReg <= measCount;
      remReg <= '0;
      divisorReg <= measPeriod;
    end else if (state == DivRun) begin
      if (trialDiff[PeriodWidth+1]) begin
        // Negative, restore the shifted remainder
        remReg <= remShift[PeriodWidth-1:0];
      end else begin
        remReg <= trialDiff[PeriodWidth-1:0];
      end
      quotReg <= quotNext;

      if (stepCnt == '0) begin
        freqOverflow <= overLimit;
        // Out of range results carry no value
        freqValue <= overLimit ? '0 : quotNext[FreqValueWidth-1:0];
      end
    end
  end

endmodule

// File: measure/secondGate.sv
/*
  Aligns measurement windows to the second boundaries of the local time, counts
  input edges and hands count and period of each finished window to the divider.
*/
module secondGate (
  input  logic                              SysClk_ClkIn,
  input  logic                              SysRstN_RstIn,
  input  logic [freqCntPkg::SecondWidth-1:0] timeSecond,
  input  logic                              timeJump,
  input  logic                              timeValid,
  input  logic                              edgePulse,
  input  logic                              measEnable,
  input  logic [freqCntPkg::PeriodWidth-1:0] measPeriodCfg,
  output logic [freqCntPkg::CountWidth-1:0]  measCount,
  output logic [freqCntPkg::PeriodWidth-1:0] measPeriod,
  output logic                              measValid
);

  import freqCntPkg::*;

  logic [SecondWidth-1:0] secondReg;
  logic [CountWidth-1:0] countReg;
  logic [CountWidth-1:0] countNext;
  // Seconds left in the running window
  logic [PeriodWidth-1:0] countdown;
  // Period of the running window, config changes wait for the next one
  logic [PeriodWidth-1:0] periodLatched;

  logic boundary;
  logic restart;
  logic startMeas;
  logic closeMeas;

  // ****************************************
  // Boundary decode
  // ****************************************
  always_comb begin
    boundary = (timeSecond != secondReg);
    // Invalid time or a jump throws the window away
    restart = !timeValid || timeJump;
    // A new window starts when the old one is done or the core is off
    startMeas = !restart && boundary &&
                ((countdown <= PeriodWidth'(1)) || !measEnable);
    closeMeas = !restart && boundary && measEnable && (countdown == PeriodWidth'(1));
    // Includes an edge seen on the boundary cycle itself
    countNext = countReg + CountWidth'(edgePulse);
  end

  // ****************************************
  // Counter and countdown
  // ****************************************
  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      secondReg <= '0;
      countReg <= '0;
      countdown <= '0;
      measValid <= 1'b0;
    end else begin
      secondReg <= timeSecond;
      measValid <= closeMeas;

      if (restart || startMeas) begin
        countReg <= '0;
      end else begin
        countReg <= countNext;
      end

      if (restart) begin
        countdown <= '0;
      end else if (startMeas) begin
        countdown <= measPeriodCfg;
      end else if (boundary) begin
        countdown <= countdown - PeriodWidth'(1);
      end
    end
  end

  // Result and period registers, loaded only on window events
  always_ff @(posedge SysClk_ClkIn) begin
    if (startMeas) begin
      periodLatched <= measPeriodCfg;
    end
    if (closeMeas) begin
      measCount <= countNext;
      measPeriod <= periodLatched;
    end
  end

endmodule

// File: sim.f
common/freqCntPkg.sv
verilog/edgeSync.sv
measure/secondGate.sv
measure/rateDivider.sv
verilog/axiLiteRegs.sv
verilog/frequencyCounter.sv
verification/tbFrequencyCounter.sv

// File: verification/tbFrequencyCounter.sv
/*
  Directed testbench for the frequency counter. Generates a shortened local second
  and a square wave input, runs AXI4-Lite accesses and checks the register results.
*/
module tbFrequencyCounter;

  timeunit 1ns;
  timeprecision 1ps;

  import freqCntPkg::*;

  localparam int ClkPeriod = 10;
  localparam int ResetCycles = 5;
  // Shortened second so that runs stay short
  localparam int CyclesPerSecond = 200;
  localparam int TbFreqLimit = 50;
  localparam int AxiTimeout = 50;
  localparam int PollLimit = 500;

  logic SysClk_ClkIn;
  logic SysRstN_RstIn;
  logic [SecondWidth-1:0] timeSecond = '0;
  logic timeJump;
  logic timeValid;
  logic freqIn = 1'b0;
  logic awValid;
  logic awReady;
  logic [AxiAddrWidth-1:0] awAddr;
  logic wValid;
  logic wReady;
  logic [AxiDataWidth-1:0] wData;
  logic bValid;
  logic bReady;
  logic [RespWidth-1:0] bResp;
  logic arValid;
  logic arReady;
  logic [AxiAddrWidth-1:0] arAddr;
  logic rValid;
  logic rReady;
  logic [RespWidth-1:0] rResp;
  logic [AxiDataWidth-1:0] rData;

  // Input generator state, half period in clock cycles
  int halfPeriod = 5;
  int secCycle;
  int phaseCnt;
  logic [31:0] lfsrState;
  int errorCount;
  int testCount;
  int failedTests;

  frequencyCounter #(
    .FreqLimit(TbFreqLimit)
  ) i_dut (
    .SysClk_ClkIn (SysClk_ClkIn),
    .SysRstN_RstIn(SysRstN_RstIn),
    .timeSecond   (timeSecond),
    .timeJump     (timeJump),
    .timeValid    (timeValid),
    .freqIn       (freqIn),
    .awValid      (awValid),
    .awReady      (awReady),
    .awAddr       (awAddr),
    .wValid       (wValid),
    .wReady       (wReady),
    .wData        (wData),
    .bValid       (bValid),
    .bReady       (bReady),
    .bResp        (bResp),
    .arValid      (arValid),
    .arReady      (arReady),
    .arAddr       (arAddr),
    .rValid       (rValid),
    .rReady       (rReady),
    .rResp        (rResp),
    .rData        (rData)
  );

  initial begin
    SysClk_ClkIn = 1'b0;
    forever #(ClkPeriod / 2) SysClk_ClkIn = ~SysClk_ClkIn;
  end

  // ****************************************
  // Time and input generators
  // ****************************************
  always @(posedge SysClk_ClkIn) begin
    if (!SysRstN_RstIn) begin
      secCycle <= 0;
      phaseCnt <= 0;
    end else if (secCycle == CyclesPerSecond - 1) begin
      // New second, input restarts low so each second holds whole periods
      secCycle <= 0;
      phaseCnt <= 0;
      timeSecond <= timeSecond + 1'b1;
      freqIn <= 1'b0;
    end else begin
      secCycle <= secCycle + 1;
      if (phaseCnt >= halfPeriod - 1) begin
        phaseCnt <= 0;
        freqIn <= ~freqIn;
      end else begin
        phaseCnt <= phaseCnt + 1;
      end
    end
  end

  // ****************************************
  // Helpers
  // ****************************************
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Expected register word for an input period given in clock cycles
  function automatic logic [AxiDataWidth-1:0] expectedWord(input int inPeriod);
    logic [AxiDataWidth-1:0] word;
    int hz;
    hz = CyclesPerSecond / inPeriod;
    word = '0;
    if (hz > TbFreqLimit) begin
      word[ErrorBit] = 1'b1;
      word[OverflowBit] = 1'b1;
    end else begin
      word[ValidBit] = 1'b1;
      word[FreqValueWidth-1:0] = FreqValueWidth'(hz);
    end
    return word;
  endfunction

  task automatic abortRun(input string reason);
    $display("Timeout: %s", reason);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic checkData(input string name, input logic [AxiDataWidth-1:0] got,
                           input logic [AxiDataWidth-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkResp(input string name, input logic [RespWidth-1:0] got,
                           input logic [RespWidth-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic axiWrite(input logic [AxiAddrWidth-1:0] addr,
                          input logic [AxiDataWidth-1:0] data,
                          output logic [RespWidth-1:0] resp);
    int waitCnt;
    @(posedge SysClk_ClkIn);
    awAddr <= addr;
    wData <= data;
    awValid <= 1'b1;
    wValid <= 1'b1;
    waitCnt = 0;
    do begin
      @(posedge SysClk_ClkIn);
      waitCnt++;
    end while (!(awReady && wReady) && waitCnt < AxiTimeout);
    if (!(awReady && wReady)) abortRun("write address and data were never accepted");
    awValid <= 1'b0;
    wValid <= 1'b0;
    // Late ready holds the response for a cycle
    @(posedge SysClk_ClkIn);
    bReady <= 1'b1;
    waitCnt = 0;
    do begin
      @(posedge SysClk_ClkIn);
      waitCnt++;
    end while (!bValid && waitCnt < AxiTimeout);
    if (!bValid) abortRun("write response never arrived");
    resp = bResp;
    bReady <= 1'b0;
  endtask

  task automatic axiRead(input logic [AxiAddrWidth-1:0] addr,
                         output logic [AxiDataWidth-1:0] data,
                         output logic [RespWidth-1:0] resp);
    int waitCnt;
    @(posedge SysClk_ClkIn);
    arAddr <= addr;
    arValid <= 1'b1;
    waitCnt = 0;
    do begin
      @(posedge SysClk_ClkIn);
      waitCnt++;
    end while (!arReady && waitCnt < AxiTimeout);
    if (!arReady) abortRun("read address was never accepted");
    arValid <= 1'b0;
    @(posedge SysClk_ClkIn);
    rReady <= 1'b1;
    waitCnt = 0;
    do begin
      @(posedge SysClk_ClkIn);
      waitCnt++;
    end while (!rValid && waitCnt < AxiTimeout);
    if (!rValid) abortRun("read data never arrived");
    data = rData;
    resp = rResp;
    rReady <= 1'b0;
  endtask

  task automatic waitSeconds(input int count);
    logic [SecondWidth-1:0] startSecond;
    int waitCnt;
    for (int n = 0; n < count; n++) begin
      startSecond = timeSecond;
      waitCnt = 0;
      while (timeSecond == startSecond && waitCnt < 2 * CyclesPerSecond) begin
        @(posedge SysClk_ClkIn);
        waitCnt++;
      end
      if (timeSecond == startSecond) abortRun("second boundary never came");
    end
  endtask

  // Reads the frequency register until it holds a result
  task automatic pollResult(output logic [AxiDataWidth-1:0] data);
    logic [RespWidth-1:0] resp;
    int polls;
    polls = 0;
    data = '0;
    while (!data[ValidBit] && !data[ErrorBit] && polls < PollLimit) begin
      axiRead(FrequencyAddr, data, resp);
      checkResp("rResp frequency", resp, 2'b00);
      polls++;
    end
    if (!data[ValidBit] && !data[ErrorBit]) abortRun("no frequency result was published");
  endtask

  // Three LFSR bits select a divisor of the second length
  task automatic pickPeriod(output int inPeriod);
    logic [2:0] index;
    index = '0;
    for (int i = 0; i < 3; i++) begin
      lfsrState = lfsrStep(lfsrState);
      index = {index[1:0], lfsrState[0]};
    end
    case (index)
      3'd0: inPeriod = 4;
      3'd1: inPeriod = 8;
      3'd2: inPeriod = 10;
      3'd3: inPeriod = 20;
      3'd4: inPeriod = 40;
      3'd5: inPeriod = 50;
      3'd6: inPeriod = 100;
      default: inPeriod = 200;
    endcase
  endtask

  task automatic runMeasurement(input int periodSec, input int inPeriod, input logic doJump);
    logic [AxiDataWidth-1:0] ctrl;
    logic [AxiDataWidth-1:0] data;
    logic [RespWidth-1:0] resp;
    ctrl = '0;
    ctrl[PeriodLsb +: PeriodWidth] = PeriodWidth'(periodSec);
    axiWrite(ControlAddr, ctrl, resp);
    checkResp("bResp control", resp, 2'b00);
    @(posedge SysClk_ClkIn);
    halfPeriod <= inPeriod / 2;
    // Two boundaries flush the old pattern out of the synchronizer
    waitSeconds(2);
    if (doJump) begin
      @(posedge SysClk_ClkIn);
      timeJump <= 1'b1;
      @(posedge SysClk_ClkIn);
      timeJump <= 1'b0;
    end
    ctrl[EnableBit] = 1'b1;
    axiWrite(ControlAddr, ctrl, resp);
    checkResp("bResp control", resp, 2'b00);
    if (doJump) begin
      // Window restarts at the first boundary after the jump
      waitSeconds(periodSec);
      repeat (CyclesPerSecond / 2) @(posedge SysClk_ClkIn);
      axiRead(FrequencyAddr, data, resp);
      checkData("frequency", data, 32'h0000_0000);
    end
    pollResult(data);
    checkData("frequency", data, expectedWord(inPeriod));
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("%s: passed", name);
    end else begin
      failedTests++;
      $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  // ****************************************
  // Tests
  // ****************************************
  task automatic registerAccess();
    int errorsBefore;
    logic [AxiDataWidth-1:0] data;
    logic [RespWidth-1:0] resp;
    errorsBefore = errorCount;
    if (awReady || wReady || bValid || arReady || rValid) begin
      $display("A ready or valid output is high after reset");
      errorCount++;
    end
    axiRead(ControlAddr, data, resp);
    checkData("control", data, 32'h0000_0100);
    checkResp("rResp control", resp, 2'b00);
    axiRead(PolarityAddr, data, resp);
    checkData("polarity", data, 32'h0000_0001);
    checkResp("rResp polarity", resp, 2'b00);
    axiRead(FrequencyAddr, data, resp);
    checkData("frequency", data, 32'h0000_0000);
    checkResp("rResp frequency", resp, 2'b00);
    axiRead(VersionAddr, data, resp);
    checkData("version", data, 32'h0001_0000);
    checkResp("rResp version", resp, 2'b00);
    // Unmapped address
    axiRead(16'h0010, data, resp);
    checkData("unmapped", data, 32'h0000_0000);
    checkResp("rResp unmapped", resp, 2'b10);
    // Version is read-only
    axiWrite(VersionAddr, 32'hFFFF_FFFF, resp);
    checkResp("bResp version", resp, 2'b10);
    axiRead(VersionAddr, data, resp);
    checkData("version", data, 32'h0001_0000);
    reportTest("register access", errorsBefore);
  endtask

  task automatic oneSecondWindow();
    int errorsBefore;
    errorsBefore = errorCount;
    runMeasurement(1, 10, 1'b0);
    reportTest("one second window", errorsBefore);
  endtask

  task automatic randomPeriodWindow();
    int errorsBefore;
    int inPeriod;
    errorsBefore = errorCount;
    pickPeriod(inPeriod);
    runMeasurement(3, inPeriod, 1'b0);
    reportTest($sformatf("three second window, input period %0d", inPeriod), errorsBefore);
  endtask

  task automatic fallingEdges();
    int errorsBefore;
    logic [RespWidth-1:0] resp;
    errorsBefore = errorCount;
    axiWrite(PolarityAddr, 32'h0, resp);
    checkResp("bResp polarity", resp, 2'b00);
    runMeasurement(1, 10, 1'b0);
    axiWrite(PolarityAddr, 32'h1, resp);
    checkResp("bResp polarity", resp, 2'b00);
    reportTest("falling edges", errorsBefore);
  endtask

  task automatic overflowResult();
    int errorsBefore;
    errorsBefore = errorCount;
    // 100 edges per second is above the limit
    runMeasurement(1, 2, 1'b0);
    reportTest("overflow", errorsBefore);
  endtask

  task automatic jumpRecovery();
    int errorsBefore;
    logic [AxiDataWidth-1:0] data;
    logic [RespWidth-1:0] resp;
    errorsBefore = errorCount;
    // Period 2 with the enable off
    axiWrite(ControlAddr, 32'h0000_0200, resp);
    checkResp("bResp control", resp, 2'b00);
    axiRead(FrequencyAddr, data, resp);
    checkData("frequency", data, 32'h0000_0000);
    runMeasurement(2, 20, 1'b1);
    reportTest("disable and time jump", errorsBefore);
  endtask

  initial begin
    SysRstN_RstIn = 1'b0;
    timeJump = 1'b0;
    timeValid = 1'b1;
    awValid = 1'b0;
    awAddr = '0;
    wValid = 1'b0;
    wData = '0;
    bReady = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    rReady = 1'b0;
    lfsrState = 32'h7122;
    errorCount = 0;
    testCount = 0;
    failedTests = 0;
    repeat (ResetCycles) @(posedge SysClk_ClkIn);
    SysRstN_RstIn <= 1'b1;

    registerAccess();
    oneSecondWindow();
    randomPeriodWindow();
    fallingEdges();
    overflowResult();
    jumpRecovery();

    $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/axiLiteRegs.sv
/*
  AXI4-Lite slave with the control, frequency, polarity and version registers.
  Serves one access at a time and holds the last frequency result.
*/
module axiLiteRegs (
  input  logic                                 SysClk_ClkIn,
  input  logic                                 SysRstN_RstIn,
  // Write address channel
  input  logic                                 awValid,
  output logic                                 awReady,
  input  logic [freqCntPkg::AxiAddrWidth-1:0]   awAddr,
  // Write data channel
  input  logic                                 wValid,
  output logic                                 wReady,
  input  logic [freqCntPkg::AxiDataWidth-1:0]   wData,
  // Write response channel
  output logic                                 bValid,
  input  logic                                 bReady,
  output logic [freqCntPkg::RespWidth-1:0]      bResp,
  // Read address channel
  input  logic                                 arValid,
  output logic                                 arReady,
  input  logic [freqCntPkg::AxiAddrWidth-1:0]   arAddr,
  // Read data channel
  output logic                                 rValid,
  input  logic                                 rReady,
  output logic [freqCntPkg::RespWidth-1:0]      rResp,
  output logic [freqCntPkg::AxiDataWidth-1:0]   rData,
  // Divider result
  input  logic [freqCntPkg::FreqValueWidth-1:0] freqValue,
  input  logic                                 freqOverflow,
  input  logic                                 freqDone,
  // Configuration
  output logic                                 measEnable,
  output logic [freqCntPkg::PeriodWidth-1:0]    measPeriodCfg,
  output logic                                 edgePolarity
);

  import freqCntPkg::*;

  axiStateT state;
  logic [AxiDataWidth-1:0] controlReg;
  logic [AxiDataWidth-1:0] frequencyReg;
  logic [AxiDataWidth-1:0] polarityReg;

  logic [AxiDataWidth-1:0] freqWord;
  logic [AxiDataWidth-1:0] readData;
  logic [RespWidth-1:0] readResp;
  logic writeHs;
  logic readHs;

  assign measEnable = controlReg[EnableBit];
  assign measPeriodCfg = controlReg[PeriodLsb +: PeriodWidth];
  assign edgePolarity = polarityReg[0];

  // Both channels must complete together for a write
  assign writeHs = awValid && awReady && wValid && wReady;
  assign readHs = arValid && arReady;

  // ****************************************
  // Result word and read mux
  // ****************************************
  always_comb begin
    freqWord = '0;
    if (freqOverflow) begin
      freqWord[ErrorBit] = 1'b1;
      freqWord[OverflowBit] = 1'b1;
    end else begin
      freqWord[ValidBit] = 1'b1;
      freqWord[FreqValueWidth-1:0] = freqValue;
    end
  end

  always_comb begin
    readResp = RespOkay;
    case (arAddr)
      ControlAddr:   readData = controlReg;
      FrequencyAddr: readData = frequencyReg;
      PolarityAddr:  readData = polarityReg;
      VersionAddr:   readData = FreqCntVersion;
      default: begin
        readData = '0;
        readResp = RespSlvErr;
      end
    endcase
  end

  // ****************************************
  // Slave FSM and registers
  // ****************************************
  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      state <= AxiIdle;
      awReady <= 1'b0;
      wReady <= 1'b0;
      bValid <= 1'b0;
      bResp <= RespOkay;
      arReady <= 1'b0;
      rValid <= 1'b0;
      rResp <= RespOkay;
      rData <= '0;
      controlReg <= ControlReset;
      frequencyReg <= '0;
      polarityReg <= {{(AxiDataWidth-1){1'b0}}, PolarityReset};
    end else begin
      // Readies drop after their handshake, valids once the master takes them
      if (awValid && awReady) awReady <= 1'b0;
      if (wValid && wReady) wReady <= 1'b0;
      if (arValid && arReady) arReady <= 1'b0;
      if (bValid && bReady) bValid <= 1'b0;
      if (rValid && rReady) rValid <= 1'b0;

      case (state)
        AxiIdle: begin
          // Writes win when both are pending
          if (awValid && wValid) begin
            awReady <= 1'b1;
            wReady <= 1'b1;
            state <= AxiWrite;
          end else if (arValid) begin
            arReady <= 1'b1;
            state <= AxiRead;
          end
        end
        AxiRead: begin
          if (readHs) begin
            rValid <= 1'b1;
            rData <= readData;
            rResp <= readResp;
            state <= AxiResp;
          end
        end
        AxiWrite: begin
          if (writeHs) begin
            bValid <= 1'b1;
            state <= AxiResp;
            case (awAddr)
              ControlAddr: begin
                controlReg <= wData & ControlMask;
                bResp <= RespOkay;
              end
              PolarityAddr: begin
                polarityReg <= wData & PolarityMask;
                bResp <= RespOkay;
              end
              // Read-only and unmapped addresses
              default: bResp <= RespSlvErr;
            endcase
          end
        end
        AxiResp: begin
          if ((bValid && bReady) || (rValid && rReady)) begin
            state <= AxiIdle;
          end
        end
        default: state <= AxiIdle;
      endcase

      // Disabled core shows no result
      if (!measEnable) begin
        frequencyReg <= '0;
      end else if (freqDone) begin
        frequencyReg <= freqWord;
      end
    end
  end

endmodule

// File: verilog/edgeSync.sv
/*
  Three-flop synchronizer for the external frequency input with a registered
  one-cycle pulse on the selected edge, rising when edgePolarity is 1.
*/
module edgeSync (
  input  logic SysClk_ClkIn,
  input  logic SysRstN_RstIn,
  input  logic freqIn,
  input  logic edgePolarity,
  output logic edgePulse
);

  // Synchronizer chain, syncReg[0] sees the asynchronous input
  logic [2:0] syncReg;
  logic riseDet;
  logic fallDet;

  // Compare the last two stages
  assign riseDet = syncReg[1] & ~syncReg[2];
  assign fallDet = ~syncReg[1] & syncReg[2];

  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      syncReg <= '0;
      edgePulse <= 1'b0;
    end else begin
      syncReg <= {syncReg[1:0], freqIn};
      // Pulse appears three cycles after the input level change
      edgePulse <= edgePolarity ? riseDet : fallDet;
    end
  end

endmodule

// File: verilog/frequencyCounter.sv
/*
  Top level of the frequency counter: synchronizer, second-aligned gate, serial
  divider and AXI4-Lite register block. FreqLimit sets the accepted range in Hz.
*/
module frequencyCounter #(
  parameter int FreqLimit = freqCntPkg::MaxFrequency
) (
  input  logic                               SysClk_ClkIn,
  input  logic                               SysRstN_RstIn,
  // Local time
  input  logic [freqCntPkg::SecondWidth-1:0]  timeSecond,
  input  logic                               timeJump,
  input  logic                               timeValid,
  // Signal under measurement
  input  logic                               freqIn,
  // AXI4-Lite slave
  input  logic                               awValid,
  output logic                               awReady,
  input  logic [freqCntPkg::AxiAddrWidth-1:0] awAddr,
  input  logic                               wValid,
  output logic                               wReady,
  input  logic [freqCntPkg::AxiDataWidth-1:0] wData,
  output logic                               bValid,
  input  logic                               bReady,
  output logic [freqCntPkg::RespWidth-1:0]    bResp,
  input  logic                               arValid,
  output logic                               arReady,
  input  logic [freqCntPkg::AxiAddrWidth-1:0] arAddr,
  output logic                               rValid,
  input  logic                               rReady,
  output logic [freqCntPkg::RespWidth-1:0]    rResp,
  output logic [freqCntPkg::AxiDataWidth-1:0] rData
);

  import freqCntPkg::*;

  logic edgePulse;
  logic edgePolarity;
  logic measEnable;
  logic [PeriodWidth-1:0] measPeriodCfg;
  logic [CountWidth-1:0] measCount;
  logic [PeriodWidth-1:0] measPeriod;
  logic measValid;
  logic [FreqValueWidth-1:0] freqValue;
  logic freqOverflow;
  logic freqDone;

  edgeSync i_edgeSync (
    .SysClk_ClkIn (SysClk_ClkIn),
    .SysRstN_RstIn(SysRstN_RstIn),
    .freqIn       (freqIn),
    .edgePolarity (edgePolarity),
    .edgePulse    (edgePulse)
  );

  secondGate i_secondGate (
    .SysClk_ClkIn (SysClk_ClkIn),
    .SysRstN_RstIn(SysRstN_RstIn),
    .timeSecond   (timeSecond),
    .timeJump     (timeJump),
    .timeValid    (timeValid),
    .edgePulse    (edgePulse),
    .measEnable   (measEnable),
    .measPeriodCfg(measPeriodCfg),
    .measCount    (measCount),
    .measPeriod   (measPeriod),
    .measValid    (measValid)
  );

  rateDivider #(
    .FreqLimit(FreqLimit)
  ) i_rateDivider (
    .SysClk_ClkIn (SysClk_ClkIn),
    .SysRstN_RstIn(SysRstN_RstIn),
    .measCount    (measCount),
    .measPeriod   (measPeriod),
    .measValid    (measValid),
    .freqValue    (freqValue),
    .freqOverflow (freqOverflow),
    .freqDone     (freqDone)
  );

  axiLiteRegs i_axiLiteRegs (
    .SysClk_ClkIn (SysClk_ClkIn),
    .SysRstN_RstIn(SysRstN_RstIn),
    .awValid      (awValid),
    .awReady      (awReady),
    .awAddr       (awAddr),
    .wValid       (wValid),
    .wReady       (wReady),
    .wData        (wData),
    .bValid       (bValid),
    .bReady       (bReady),
    .bResp        (bResp),
    .arValid      (arValid),
    .arReady      (arReady),
    .arAddr       (arAddr),
    .rValid       (rValid),
    .rReady       (rReady),
    .rResp        (rResp),
    .rData        (rData),
    .freqValue    (freqValue),
    .freqOverflow (freqOverflow),
    .freqDone     (freqDone),
    .measEnable   (measEnable),
    .measPeriodCfg(measPeriodCfg),
    .edgePolarity (edgePolarity)
  );

endmodule
